// ==== rtl/core_pkg.sv ====
// Shared widths, encodings and control types for the RV64I core.
// Only the opcodes of the supported subset are listed here.
// All other encodings are treated as no-ops by the decoder.

`default_nettype none

package core_pkg;

    // --------------------------------------------------
    // Sizes.
    // --------------------------------------------------
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int SHAMT_W    = $clog2(XLEN);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // --------------------------------------------------
    // Encodings.
    // --------------------------------------------------

    // RISC-V major opcodes, instr[6:0].
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_PASS_B = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_JUMP = 3'd4
    } branch_e;

    // Write-back source.
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

    // --------------------------------------------------
    // Structs.
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e alu_op;
        logic    src_b_is_imm;
        logic    reg_we;
        wb_sel_e wb_sel;
        logic    mem_we;
        branch_e branch;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } dmem_req_t;

endpackage

`default_nettype wire

// ==== rtl/register_file.sv ====
// 32 x 64-bit integer register file.
// Reads are combinational; the single write port updates on the clock edge.
// x0 always reads zero since writes to it are dropped.

`default_nettype none

module register_file (
    input  logic                             clk,
    input  logic                             arst,

    // Read ports.
    input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0]  i_rs2_addr,

    // Write port.
    input  logic [core_pkg::REG_ADDR_W-1:0]  i_rd_addr,
    input  logic                             i_rd_we,
    input  logic [core_pkg::XLEN-1:0]        i_rd_data,

    output logic [core_pkg::XLEN-1:0]        o_rs1_data,
    output logic [core_pkg::XLEN-1:0]        o_rs2_data
);

    // Register array.
    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    logic wr_en;

    // Writes to x0 are discarded.
    assign wr_en = i_rd_we && (i_rd_addr != '0);

    // --------------------------------------------------
    // Write port.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // --------------------------------------------------
    // Read ports.
    // --------------------------------------------------
    assign o_rs1_data = regs[i_rs1_addr];
    assign o_rs2_data = regs[i_rs2_addr];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// Combinational 64-bit ALU.
// Shift amounts come from the low 6 bits of operand b.
// SLT is signed; there is no unsigned compare in this core.

`default_nettype none

module alu (
    input  core_pkg::alu_op_e          i_op,
    input  logic [core_pkg::XLEN-1:0]  i_a,
    input  logic [core_pkg::XLEN-1:0]  i_b,
    output logic [core_pkg::XLEN-1:0]  o_result
);

    logic [core_pkg::SHAMT_W-1:0] shamt;
    logic                         lt;

    assign shamt = i_b[core_pkg::SHAMT_W-1:0];
    assign lt    = $signed(i_a) < $signed(i_b);

    // Operation select.
    always_comb begin
        o_result = '0;
        case (i_op)
            core_pkg::ALU_ADD: begin
                o_result = i_a + i_b;
            end
            core_pkg::ALU_SUB: begin
                o_result = i_a - i_b;
            end
            core_pkg::ALU_AND: begin
                o_result = i_a & i_b;
            end
            core_pkg::ALU_OR: begin
                o_result = i_a | i_b;
            end
            core_pkg::ALU_XOR: begin
                o_result = i_a ^ i_b;
            end
            core_pkg::ALU_SLT: begin
                o_result[0] = lt;
            end
            core_pkg::ALU_SLL: begin
                o_result = i_a << shamt;
            end
            core_pkg::ALU_SRL: begin
                o_result = i_a >> shamt;
            end
            core_pkg::ALU_SRA: begin
                o_result = $signed(i_a) >>> shamt;
            end
            // Used by lui, the immediate arrives on b.
            core_pkg::ALU_PASS_B: begin
                o_result = i_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
// RV64I instruction decoder for the supported subset.
// Any encoding outside the subset yields a no-op control word:
// no register write, no store and no branch.

`default_nettype none

module decoder (
    input  logic [core_pkg::ILEN-1:0]        i_instr,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rs2_addr,
    output logic [core_pkg::REG_ADDR_W-1:0]  o_rd_addr,
    output logic [core_pkg::XLEN-1:0]        o_imm,
    output core_pkg::ctrl_t                  o_ctrl
);

    core_pkg::opcode_e opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    // Sign-extended immediates of every format.
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_j;

    // --------------------------------------------------
    // Field extraction.
    // --------------------------------------------------
    assign opcode     = core_pkg::opcode_e'(i_instr[6:0]);
    assign funct3     = i_instr[14:12];
    assign funct7     = i_instr[31:25];
    assign o_rd_addr  = i_instr[11:7];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    assign imm_i = {{(core_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{(core_pkg::XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{(core_pkg::XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {{(core_pkg::XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
    assign imm_j = {{(core_pkg::XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // --------------------------------------------------
    // Control word.
    // --------------------------------------------------
    always_comb begin
        o_ctrl.alu_op       = core_pkg::ALU_ADD;
        o_ctrl.src_b_is_imm = 1'b0;
        o_ctrl.reg_we       = 1'b0;
        o_ctrl.wb_sel       = core_pkg::WB_ALU;
        o_ctrl.mem_we       = 1'b0;
        o_ctrl.branch       = core_pkg::BR_NONE;
        o_imm               = imm_i;

        case (opcode)
            core_pkg::OPC_OP: begin
                o_ctrl.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_ctrl.alu_op = core_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: o_ctrl.alu_op = core_pkg::ALU_SUB;
                    {7'b0000000, 3'b001}: o_ctrl.alu_op = core_pkg::ALU_SLL;
                    {7'b0000000, 3'b010}: o_ctrl.alu_op = core_pkg::ALU_SLT;
                    {7'b0000000, 3'b100}: o_ctrl.alu_op = core_pkg::ALU_XOR;
                    {7'b0000000, 3'b101}: o_ctrl.alu_op = core_pkg::ALU_SRL;
                    {7'b0100000, 3'b101}: o_ctrl.alu_op = core_pkg::ALU_SRA;
                    {7'b0000000, 3'b110}: o_ctrl.alu_op = core_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: o_ctrl.alu_op = core_pkg::ALU_AND;
                    default:              o_ctrl.reg_we = 1'b0;
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                o_ctrl.src_b_is_imm = 1'b1;
                o_ctrl.reg_we       = 1'b1;
                case (funct3)
                    3'b000:  o_ctrl.alu_op = core_pkg::ALU_ADD;
                    3'b010:  o_ctrl.alu_op = core_pkg::ALU_SLT;
                    3'b100:  o_ctrl.alu_op = core_pkg::ALU_XOR;
                    3'b110:  o_ctrl.alu_op = core_pkg::ALU_OR;
                    3'b111:  o_ctrl.alu_op = core_pkg::ALU_AND;
                    // Immediate shifts are outside the subset.
                    default: o_ctrl.reg_we = 1'b0;
                endcase
            end
            core_pkg::OPC_LUI: begin
                o_ctrl.alu_op       = core_pkg::ALU_PASS_B;
                o_ctrl.src_b_is_imm = 1'b1;
                o_ctrl.reg_we       = 1'b1;
                o_imm               = imm_u;
            end
            core_pkg::OPC_LOAD: begin
                o_ctrl.src_b_is_imm = 1'b1;
                o_ctrl.wb_sel       = core_pkg::WB_MEM;
                o_ctrl.reg_we       = (funct3 == 3'b011);
            end
            core_pkg::OPC_STORE: begin
                o_ctrl.src_b_is_imm = 1'b1;
                o_ctrl.mem_we       = (funct3 == 3'b011);
                o_imm               = imm_s;
            end
            core_pkg::OPC_BRANCH: begin
                o_imm = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.branch = core_pkg::BR_EQ;
                    3'b001:  o_ctrl.branch = core_pkg::BR_NE;
                    3'b100:  o_ctrl.branch = core_pkg::BR_LT;
                    default: o_ctrl.branch = core_pkg::BR_NONE;
                endcase
            end
            core_pkg::OPC_JAL: begin
                o_ctrl.reg_we = 1'b1;
                o_ctrl.wb_sel = core_pkg::WB_LINK;
                o_ctrl.branch = core_pkg::BR_JUMP;
                o_imm         = imm_j;
            end
            default: begin
                // Unknown opcode, keep the no-op defaults.
                o_imm = imm_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/pc_unit.sv ====
// Program counter with branch resolution.
// The taken decision is combinational; the PC loads on every clock edge.
// Target addresses are not checked for alignment.

`default_nettype none

module pc_unit (
    input  logic                       clk,
    input  logic                       arst,
    input  core_pkg::branch_e          i_branch,
    input  logic [core_pkg::XLEN-1:0]  i_rs1_data,
    input  logic [core_pkg::XLEN-1:0]  i_rs2_data,
    input  logic [core_pkg::XLEN-1:0]  i_imm,
    output logic [core_pkg::XLEN-1:0]  o_pc
);

    logic                      taken;
    logic [core_pkg::XLEN-1:0] pc_next;

    // Branch resolution.
    always_comb begin
        case (i_branch)
            core_pkg::BR_EQ:   taken = (i_rs1_data == i_rs2_data);
            core_pkg::BR_NE:   taken = (i_rs1_data != i_rs2_data);
            core_pkg::BR_LT:   taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            core_pkg::BR_JUMP: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    // PC relative target or fall through.
    assign pc_next = taken ? (o_pc + i_imm) : (o_pc + 'd4);

    // --------------------------------------------------
    // PC register.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            o_pc <= core_pkg::RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
// Single-cycle RV64I core top.
// One instruction retires per clock; there is no stall or handshake.
// Instruction and data reads must return in the same cycle.
// Only 64-bit ld and sd reach the data port.

`default_nettype none

module core_top (
    input  logic                       clk,
    input  logic                       arst,

    // Instruction port.
    output logic [core_pkg::XLEN-1:0]  o_imem_addr,
    input  logic [core_pkg::ILEN-1:0]  i_instr,

    // Data port.
    output core_pkg::dmem_req_t        o_dmem,
    input  logic [core_pkg::XLEN-1:0]  i_dmem_rdata
);

    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [core_pkg::XLEN-1:0]       imm;
    core_pkg::ctrl_t                 ctrl;

    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic [core_pkg::XLEN-1:0] alu_b;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic [core_pkg::XLEN-1:0] wb_data;
    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] link;

    // --------------------------------------------------
    // Datapath blocks.
    // --------------------------------------------------
    decoder u_decoder (
        .i_instr    (i_instr),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .o_rd_addr  (rd_addr),
        .o_imm      (imm),
        .o_ctrl     (ctrl)
    );

    register_file u_register_file (
        .clk        (clk),
        .arst       (arst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_rd_addr  (rd_addr),
        .i_rd_we    (ctrl.reg_we),
        .i_rd_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    alu u_alu (
        .i_op     (ctrl.alu_op),
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    pc_unit u_pc_unit (
        .clk        (clk),
        .arst       (arst),
        .i_branch   (ctrl.branch),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_imm      (imm),
        .o_pc       (pc)
    );

    // Operand B select.
    assign alu_b = ctrl.src_b_is_imm ? imm : rs2_data;

    // Return address for jal.
    assign link = pc + 'd4;

    // --------------------------------------------------
    // Write-back select.
    // --------------------------------------------------
    always_comb begin
        case (ctrl.wb_sel)
            core_pkg::WB_MEM:  wb_data = i_dmem_rdata;
            core_pkg::WB_LINK: wb_data = link;
            default:           wb_data = alu_result;
        endcase
    end

    // Memory ports.
    assign o_imem_addr  = pc;
    assign o_dmem.addr  = alu_result;
    assign o_dmem.wdata = rs2_data;
    assign o_dmem.we    = ctrl.mem_we;

endmodule

`default_nettype wire

// ==== bench/core_props.sv ====
// Port checks for the core, bound into every core_top instance.
// Assumes the reset PC is already loaded on the first clock edge of reset.

`default_nettype none

module core_props (
    input logic                       clk,
    input logic                       arst,
    input logic [core_pkg::XLEN-1:0]  i_imem_addr,
    input core_pkg::dmem_req_t        i_dmem
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed checks, read by the testbench.
    int fail_count = 0;

    // --------------------------------------------------
    // Fetch address.
    // --------------------------------------------------
    reset_pc_held: assert property (@(posedge clk) arst |-> i_imem_addr == core_pkg::RESET_PC)
        else begin
            fail_count++;
            $error("PC is not the reset address while arst is high");
        end

    first_fetch: assert property (@(posedge clk) $fell(arst) |-> i_imem_addr == core_pkg::RESET_PC)
        else begin
            fail_count++;
            $error("First fetch after reset is not at the reset address");
        end

    fetch_aligned: assert property (@(posedge clk) i_imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("Fetch address is not word aligned");
        end

    // --------------------------------------------------
    // Data port.
    // --------------------------------------------------
    we_known: assert property (@(posedge clk) disable iff (arst) !$isunknown(i_dmem.we))
        else begin
            fail_count++;
            $error("Data write enable is unknown");
        end

    store_aligned: assert property (@(posedge clk) disable iff (arst)
                                    i_dmem.we |-> i_dmem.addr[2:0] == 3'b000)
        else begin
            fail_count++;
            $error("Store address is not doubleword aligned");
        end

endmodule

bind core_top core_props u_props (
    .clk         (clk),
    .arst        (arst),
    .i_imem_addr (o_imem_addr),
    .i_dmem      (o_dmem)
);

`default_nettype wire

// ==== bench/core_tb.sv ====
// Testbench for the single-cycle core.
// Runs a hand-assembled program from a ROM and checks every store in order.
// The program ends in a jal-to-self loop, which marks the end of the run.
// Instruction and data reads are modeled as combinational lookups.

`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                arst;
    logic [63:0]         imem_addr;
    logic [31:0]         instr;
    core_pkg::dmem_req_t dmem_req;
    logic [63:0]         dmem_rdata;

    logic [31:0] rom [64];
    logic [63:0] dmem [32];

    // Expected stores, in program order.
    logic [63:0] exp_addr [32];
    logic [63:0] exp_data [32];
    string       exp_name [32];

    int          n_instr = 0;
    int          n_exp = 0;
    int          n_seen = 0;
    int          cycles;
    logic [63:0] end_pc;

    core_top i_dut (
        .clk          (clk),
        .arst         (arst),
        .o_imem_addr  (imem_addr),
        .i_instr      (instr),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------------------------------------
    // Memory models.
    // --------------------------------------------------
    assign instr      = rom[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:3]];

    always @(posedge clk) begin
        if (!arst && dmem_req.we) begin
            dmem[dmem_req.addr[7:3]] <= dmem_req.wdata;
        end
    end

    // --------------------------------------------------
    // Instruction encoders, standard RV64I formats.
    // --------------------------------------------------
    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int f3, input int rd, input int rs1,
                                           input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] ld_dword(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_dword(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b011, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] lui_upper(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jal_rel(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[n_instr] = word;
        n_instr++;
    endtask

    task automatic expect_store(input string name, input int addr, input logic [63:0] data);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = 64'(addr);
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0000_0000;
        end
        // Operands x1 = 100 and x2 = -7.
        emit(i_type(0, 1, 0, 100));
        emit(i_type(0, 2, 0, -7));
        // Register ops. Shifts by x1 use 36, the low 6 bits of 100.
        emit(r_type(0, 0, 3, 1, 2));
        emit(sd_dword(3, 0, 0));
        emit(r_type(32, 0, 4, 1, 2));
        emit(sd_dword(4, 0, 8));
        emit(r_type(0, 7, 5, 1, 2));
        emit(sd_dword(5, 0, 16));
        emit(r_type(0, 6, 6, 1, 2));
        emit(sd_dword(6, 0, 24));
        emit(r_type(0, 4, 7, 1, 2));
        emit(sd_dword(7, 0, 32));
        emit(r_type(0, 2, 8, 2, 1));
        emit(sd_dword(8, 0, 40));
        emit(r_type(0, 1, 9, 1, 1));
        emit(sd_dword(9, 0, 48));
        emit(r_type(32, 5, 10, 2, 1));
        emit(sd_dword(10, 0, 56));
        emit(r_type(0, 5, 11, 2, 1));
        emit(sd_dword(11, 0, 64));
        // Immediate ops, then lui.
        emit(i_type(7, 12, 2, 'hF0));
        emit(sd_dword(12, 0, 72));
        emit(i_type(6, 13, 1, -256));
        emit(sd_dword(13, 0, 80));
        emit(i_type(4, 14, 1, 'h7FF));
        emit(sd_dword(14, 0, 88));
        emit(i_type(2, 15, 2, -6));
        emit(sd_dword(15, 0, 96));
        emit(sd_dword(2, 0, 104));
        emit(lui_upper(16, 'h80000));
        emit(sd_dword(16, 0, 112));
        // Write to x0 is dropped.
        emit(i_type(0, 0, 0, 55));
        emit(sd_dword(0, 0, 120));
        // Load back the ori result.
        emit(ld_dword(17, 0, 80));
        emit(sd_dword(17, 0, 128));
        // Taken beq, bne and blt each skip a poison store from x20.
        emit(i_type(0, 20, 0, 'h666));
        emit(b_type(0, 1, 1, 8));
        emit(sd_dword(20, 0, 248));
        emit(b_type(1, 1, 2, 8));
        emit(sd_dword(20, 0, 248));
        emit(b_type(4, 2, 1, 8));
        emit(sd_dword(20, 0, 248));
        // Not taken, so each falls through to its store.
        emit(b_type(0, 1, 2, 8));
        emit(sd_dword(1, 0, 136));
        emit(b_type(1, 1, 1, 8));
        emit(sd_dword(2, 0, 144));
        emit(b_type(4, 1, 2, 8));
        emit(sd_dword(3, 0, 152));
        // The jal sits at 192, so its link is 196.
        emit(jal_rel(21, 8));
        emit(sd_dword(20, 0, 248));
        emit(sd_dword(21, 0, 160));
        emit(jal_rel(0, 0));
    endtask

    task automatic load_expected();
        expect_store("add", 0, 64'h0000_0000_0000_005D);
        expect_store("sub", 8, 64'h0000_0000_0000_006B);
        expect_store("and", 16, 64'h0000_0000_0000_0060);
        expect_store("or", 24, 64'hFFFF_FFFF_FFFF_FFFD);
        expect_store("xor", 32, 64'hFFFF_FFFF_FFFF_FF9D);
        expect_store("slt", 40, 64'h0000_0000_0000_0001);
        expect_store("sll", 48, 64'h0000_0640_0000_0000);
        expect_store("sra", 56, 64'hFFFF_FFFF_FFFF_FFFF);
        expect_store("srl", 64, 64'h0000_0000_0FFF_FFFF);
        expect_store("andi", 72, 64'h0000_0000_0000_00F0);
        expect_store("ori", 80, 64'hFFFF_FFFF_FFFF_FF64);
        expect_store("xori", 88, 64'h0000_0000_0000_079B);
        expect_store("slti", 96, 64'h0000_0000_0000_0001);
        expect_store("addi", 104, 64'hFFFF_FFFF_FFFF_FFF9);
        expect_store("lui", 112, 64'hFFFF_FFFF_8000_0000);
        expect_store("x0", 120, 64'h0000_0000_0000_0000);
        expect_store("ld", 128, 64'hFFFF_FFFF_FFFF_FF64);
        expect_store("beq_not_taken", 136, 64'h0000_0000_0000_0064);
        expect_store("bne_not_taken", 144, 64'hFFFF_FFFF_FFFF_FFF9);
        expect_store("blt_not_taken", 152, 64'h0000_0000_0000_005D);
        expect_store("jal_link", 160, 64'h0000_0000_0000_00C4);
    endtask

    // --------------------------------------------------
    // Store checker and cycle counter.
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!arst && dmem_req.we) begin
            if (n_seen >= n_exp) begin
                $display("A store to address %h came after the last expected store",
                         dmem_req.addr);
                $display("Testbench failed");
                $fatal(1, "unexpected store");
            end else begin
                store_match: assert (dmem_req.addr === exp_addr[n_seen]
                                     && dmem_req.wdata === exp_data[n_seen])
                    n_seen <= n_seen + 1;
                else begin
                    $display("[ERROR] %s: expected addr %h data %h, actual addr %h data %h",
                             exp_name[n_seen], exp_addr[n_seen], exp_data[n_seen],
                             dmem_req.addr, dmem_req.wdata);
                    $display("Testbench failed");
                    $fatal(1, "store mismatch");
                end
            end
        end
    end

    // A failed port property ends the run at once.
    always @(negedge clk) begin
        if (i_dut.u_props.fail_count != 0) begin
            $display("A port property of the core failed");
            $display("Testbench failed");
            $fatal(1, "property failure");
        end
    end

    always @(posedge clk or posedge arst) begin
        if (arst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // --------------------------------------------------
    // Main sequence.
    // --------------------------------------------------
    initial begin
        arst <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            dmem[i] <= {2{32'hD0D0_0000 + 32'(i)}};
        end
        load_program();
        load_expected();
        end_pc = 64'(4 * (n_instr - 1));
        repeat (3) @(posedge clk);
        arst <= 1'b0;
        // About 50 instructions retire, so 200 cycles is ample.
        while (imem_addr != end_pc && cycles < 200) begin
            @(negedge clk);
        end
        if (cycles >= 200) begin
            $display("Timeout: the final loop was not reached within 200 cycles");
            $display("Testbench failed");
            $fatal(1, "timeout");
        end else if (n_seen != n_exp) begin
            $display("Only %0d of %0d expected stores were seen", n_seen, n_exp);
            $display("Testbench failed");
            $fatal(1, "missing stores");
        end else if (i_dut.u_props.fail_count != 0) begin
            $display("%0d property assertions failed", i_dut.u_props.fail_count);
            $display("Testbench failed");
            $fatal(1, "property failure");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/core_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/decoder.sv
rtl/pc_unit.sv
rtl/core_top.sv
bench/core_props.sv
bench/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
# The error limit lets property failures run on to the testbench verdict.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_tb -f list.f &&
./obj_dir/Vcore_tb +verilator+error+limit+100 | tee /dev/stderr |
    grep -qx "Testbench passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
